// ==== mem_ctrl_pkg.sv ====
// Shared definitions for the memory bus controller
// Address view, source and size codes, widths and FSM state encodings
package mem_ctrl_pkg;

   localparam int BEAT_W  = 32;
   localparam int BLOCK_W = 128;
   localparam int LINE_W  = 256;

   // Bus byte address, or the same bits split into row, half and byte offset
   typedef union packed
   {
      logic [15:0] raw;
      struct packed
      {
         logic [10:0] line;
         logic        half;
         logic [3:0]  offset;
      } f;
   } mem_addr_u;

   // One-hot requester
   typedef logic [2:0] src_t;
   localparam src_t SRC_IC  = 3'b001;
   localparam src_t SRC_DC  = 3'b010;
   localparam src_t SRC_DMA = 3'b100;

   // Bytes written are 2**code
   typedef logic [2:0] wsize_t;

   typedef enum logic [2:0]
   {
      S_IDLE  = 3'b001,
      S_ACK   = 3'b010,
      S_WBEAT = 3'b100
   } slave_state_t;

   typedef enum logic [3:0]
   {
      M_IDLE  = 4'b0001,
      M_REQ   = 4'b0010,
      M_ADDR  = 4'b0100,
      M_BEATS = 4'b1000
   } master_state_t;

endpackage

// ==== bus_slave_capture.sv ====
// Bus slave stage with request acknowledge and write-beat assembly
`timescale 1ns/1ps

module bus_slave_capture
(
   input  logic                             bus_clk,
   input  logic                             rst_n,
   input  logic                             dest_in,
   input  logic                             bus_rw,
   input  logic [mem_ctrl_pkg::BEAT_W-1:0]  bus_d,
   input  logic                             wr_latch_empty,
   output logic                             ack_out,
   output logic [mem_ctrl_pkg::BLOCK_W-1:0] blk_data,
   output logic                             blk_load
);

   mem_ctrl_pkg::slave_state_t state;
   logic                       rw_q;
   logic [1:0]                 beat_cnt;
   logic                       wr_load_q;

   always_ff @(posedge bus_clk)
   begin
      if (!rst_n)
      begin
         state     <= mem_ctrl_pkg::S_IDLE;
         rw_q      <= 1'b0;
         beat_cnt  <= 2'd0;
         wr_load_q <= 1'b0;
      end
      else
      begin
         wr_load_q <= 1'b0;
         case (state)
            mem_ctrl_pkg::S_IDLE:
            begin
               // Only take a request the write latch can hold
               if (dest_in && wr_latch_empty)
               begin
                  state <= mem_ctrl_pkg::S_ACK;
                  rw_q  <= bus_rw;
               end
            end
            mem_ctrl_pkg::S_ACK:
            begin
               beat_cnt <= 2'd0;
               state    <= rw_q ? mem_ctrl_pkg::S_WBEAT : mem_ctrl_pkg::S_IDLE;
            end
            mem_ctrl_pkg::S_WBEAT:
            begin
               beat_cnt <= beat_cnt + 2'd1;
               if (beat_cnt == 2'd3)
               begin
                  wr_load_q <= 1'b1;
                  state     <= mem_ctrl_pkg::S_IDLE;
               end
            end
            default:
               state <= mem_ctrl_pkg::S_IDLE;
         endcase
      end
   end

   // Beat n lands in word n, low word first
   always_ff @(posedge bus_clk)
   begin
      if (state == mem_ctrl_pkg::S_WBEAT)
         blk_data[beat_cnt*mem_ctrl_pkg::BEAT_W +: mem_ctrl_pkg::BEAT_W] <= bus_d;
   end

   assign ack_out  = (state == mem_ctrl_pkg::S_ACK);
   // A read has no data phase so it loads with the acknowledge
   assign blk_load = (ack_out && !rw_q) || wr_load_q;

endmodule

// ==== request_latches.sv ====
// Two-entry request pipeline made of a write latch and a read latch
`timescale 1ns/1ps

module request_latches
(
   input  logic                             bus_clk,
   input  logic                             rst_n,
   input  logic                             dest_in,
   input  logic                             blk_load,
   input  logic [mem_ctrl_pkg::BLOCK_W-1:0] blk_data,
   input  logic [15:0]                      bus_a,
   input  logic                             bus_rw,
   input  mem_ctrl_pkg::wsize_t             bus_size,
   input  mem_ctrl_pkg::src_t               bus_src,
   input  logic                             access_done,
   output logic                             wr_latch_empty,
   output logic                             rd_valid,
   output mem_ctrl_pkg::mem_addr_u          rd_addr,
   output mem_ctrl_pkg::src_t               rd_src,
   output mem_ctrl_pkg::wsize_t             rd_size,
   output logic                             rd_rw,
   output logic [mem_ctrl_pkg::BLOCK_W-1:0] rd_data
);

   logic                             wr_rsv;
   logic                             wr_valid;
   mem_ctrl_pkg::mem_addr_u          wr_addr;
   mem_ctrl_pkg::src_t               wr_src;
   mem_ctrl_pkg::wsize_t             wr_size;
   logic                             wr_rw;
   logic [mem_ctrl_pkg::BLOCK_W-1:0] wr_data;
   logic                             accept;
   logic                             advance;

   // Write latch is reserved from the accepted strobe until it moves on,
   // so it matches the slave's own accept condition
   assign wr_latch_empty = !wr_rsv;
   assign accept         = dest_in && !wr_rsv;
   assign advance        = wr_valid && (!rd_valid || access_done);

   always_ff @(posedge bus_clk)
   begin
      if (!rst_n)
      begin
         wr_rsv   <= 1'b0;
         wr_valid <= 1'b0;
         rd_valid <= 1'b0;
      end
      else
      begin
         if (advance)
         begin
            wr_rsv   <= 1'b0;
            wr_valid <= 1'b0;
         end
         if (accept)
            wr_rsv <= 1'b1;
         if (blk_load)
            wr_valid <= 1'b1;

         if (advance)
            rd_valid <= 1'b1;
         else if (access_done)
            rd_valid <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Payload
   always_ff @(posedge bus_clk)
   begin
      if (accept)
      begin
         wr_addr.raw <= bus_a;
         wr_src      <= bus_src;
         wr_size     <= bus_size;
         wr_rw       <= bus_rw;
      end
      if (blk_load)
         wr_data <= blk_data;
      if (advance)
      begin
         rd_addr <= wr_addr;
         rd_src  <= wr_src;
         rd_size <= wr_size;
         rd_rw   <= wr_rw;
         rd_data <= wr_data;
      end
   end

endmodule

// ==== mem_access_unit.sv ====
// Memory access timing, write shift and byte mask, read half select
`timescale 1ns/1ps

module mem_access_unit
#(
   parameter int MEM_LINES = 64
)
(
   input  logic                               bus_clk,
   input  logic                               rst_n,
   input  logic                               rd_valid,
   input  mem_ctrl_pkg::mem_addr_u            rd_addr,
   input  mem_ctrl_pkg::wsize_t               rd_size,
   input  logic                               rd_rw,
   input  logic [mem_ctrl_pkg::BLOCK_W-1:0]   rd_data,
   input  logic                               ret_done,
   output logic [$clog2(MEM_LINES)-1:0]       mem_addr,
   output logic                               mem_en,
   output logic                               mem_wr,
   output logic [mem_ctrl_pkg::LINE_W-1:0]    mem_wdata,
   output logic [mem_ctrl_pkg::LINE_W/8-1:0]  mem_be,
   input  logic [mem_ctrl_pkg::LINE_W-1:0]    mem_rdata,
   output logic                               access_done,
   output logic                               ret_ready,
   output logic [mem_ctrl_pkg::BLOCK_W-1:0]   ret_data
);

   logic [4:0]                       timer;
   logic [10:0]                      line_mod;
   logic [16:0]                      size_ones;
   logic [31:0]                      mask_wide;
   logic [15:0]                      half_mask;
   logic [mem_ctrl_pkg::BLOCK_W-1:0] wdata_shifted;
   logic                             rd_capture;

   // Timer gains one set bit per cycle and restarts on an empty or clearing latch
   always_ff @(posedge bus_clk)
   begin
      if (!rst_n)
         timer <= '0;
      else if (!rd_valid || access_done)
         timer <= 5'b00001;
      else
         timer <= {timer[3:0], 1'b1};
   end

   assign line_mod    = 11'(rd_addr.f.line % MEM_LINES);
   assign mem_addr    = line_mod[$clog2(MEM_LINES)-1:0];
   assign mem_en      = timer[2];
   assign mem_wr      = timer[2] && rd_rw;
   assign access_done = rd_valid && (rd_rw ? timer[4] : ret_done);

   ////////////////////////////////////////////////////////////////////////////
   // Write path
   always_comb
   begin
      case (rd_size)
         3'd0:    size_ones = 17'h0_0001;
         3'd1:    size_ones = 17'h0_0003;
         3'd2:    size_ones = 17'h0_000f;
         3'd3:    size_ones = 17'h0_00ff;
         default: size_ones = 17'h0_ffff;
      endcase
   end

   // Bytes pushed past the end of the half are dropped
   assign mask_wide     = {15'd0, size_ones} << rd_addr.f.offset;
   assign half_mask     = mask_wide[15:0];
   assign wdata_shifted = rd_data << {rd_addr.f.offset, 3'b000};
   assign mem_wdata     = {wdata_shifted, wdata_shifted};
   assign mem_be        = rd_addr.f.half ? {half_mask, 16'h0000} : {16'h0000, half_mask};

   ////////////////////////////////////////////////////////////////////////////
   // Read path
   // Row data arrives one cycle after the first enable
   assign rd_capture = rd_valid && !rd_rw && timer[3] && !timer[4];

   always_ff @(posedge bus_clk)
   begin
      if (rd_capture)
         ret_data <= rd_addr.f.half ? mem_rdata[255:128] : mem_rdata[127:0];
   end

   always_ff @(posedge bus_clk)
   begin
      if (!rst_n)
         ret_ready <= 1'b0;
      else if (ret_done)
         ret_ready <= 1'b0;
      else if (rd_capture)
         ret_ready <= 1'b1;
   end

endmodule

// ==== mem_array.sv ====
// Behavioural row memory with byte enables and registered read
`timescale 1ns/1ps

module mem_array
#(
   parameter int MEM_LINES = 64
)
(
   input  logic                              bus_clk,
   input  logic [$clog2(MEM_LINES)-1:0]      mem_addr,
   input  logic                              mem_en,
   input  logic                              mem_wr,
   input  logic [mem_ctrl_pkg::LINE_W-1:0]   mem_wdata,
   input  logic [mem_ctrl_pkg::LINE_W/8-1:0] mem_be,
   output logic [mem_ctrl_pkg::LINE_W-1:0]   mem_rdata
);

   logic [mem_ctrl_pkg::LINE_W-1:0] rows [MEM_LINES];

   always_ff @(posedge bus_clk)
   begin
      if (mem_en)
      begin
         if (mem_wr)
         begin
            // Only enabled bytes change
            for (int b = 0; b < mem_ctrl_pkg::LINE_W/8; b++)
            begin
               if (mem_be[b])
                  rows[mem_addr][b*8 +: 8] <= mem_wdata[b*8 +: 8];
            end
         end
         // Old row contents on a write cycle
         mem_rdata <= rows[mem_addr];
      end
   end

endmodule

// ==== bus_return_master.sv ====
// Bus master stage returning read data to the requesting cache
`timescale 1ns/1ps

module bus_return_master
(
   input  logic                             bus_clk,
   input  logic                             rst_n,
   input  logic                             ret_ready,
   input  mem_ctrl_pkg::mem_addr_u          rd_addr,
   input  mem_ctrl_pkg::src_t               rd_src,
   input  logic [mem_ctrl_pkg::BLOCK_W-1:0] ret_data,
   input  logic                             bg,
   input  logic                             ack_in,
   output logic                             br,
   output logic                             dest_out_ic,
   output logic                             dest_out_dc,
   output logic [15:0]                      out_a,
   output logic [mem_ctrl_pkg::BEAT_W-1:0]  out_d,
   output logic                             out_d_valid,
   output logic                             ret_done
);

   mem_ctrl_pkg::master_state_t state;
   logic [1:0]                  beat_cnt;

   always_ff @(posedge bus_clk)
   begin
      if (!rst_n)
      begin
         state       <= mem_ctrl_pkg::M_IDLE;
         beat_cnt    <= 2'd0;
         dest_out_ic <= 1'b0;
         dest_out_dc <= 1'b0;
      end
      else
      begin
         // Destination strobe is the first cycle after grant
         dest_out_ic <= (state == mem_ctrl_pkg::M_REQ) && bg &&
                        (rd_src == mem_ctrl_pkg::SRC_IC);
         dest_out_dc <= (state == mem_ctrl_pkg::M_REQ) && bg &&
                        (rd_src == mem_ctrl_pkg::SRC_DC);
         case (state)
            mem_ctrl_pkg::M_IDLE:
               if (ret_ready)
                  state <= mem_ctrl_pkg::M_REQ;
            mem_ctrl_pkg::M_REQ:
               if (bg)
                  state <= mem_ctrl_pkg::M_ADDR;
            mem_ctrl_pkg::M_ADDR:
            begin
               beat_cnt <= 2'd0;
               // DMA has no strobe and sends no acknowledge
               if (ack_in || rd_src == mem_ctrl_pkg::SRC_DMA)
                  state <= mem_ctrl_pkg::M_BEATS;
            end
            mem_ctrl_pkg::M_BEATS:
            begin
               beat_cnt <= beat_cnt + 2'd1;
               if (beat_cnt == 2'd3)
                  state <= mem_ctrl_pkg::M_IDLE;
            end
            default:
               state <= mem_ctrl_pkg::M_IDLE;
         endcase
      end
   end

   assign br          = (state == mem_ctrl_pkg::M_REQ);
   assign out_a       = rd_addr.raw;
   assign out_d       = ret_data[beat_cnt*mem_ctrl_pkg::BEAT_W +: mem_ctrl_pkg::BEAT_W];
   assign out_d_valid = (state == mem_ctrl_pkg::M_BEATS);
   assign ret_done    = out_d_valid && (beat_cnt == 2'd3);

endmodule

// ==== mem_bus_controller.sv ====
// Top level of the memory bus controller
// Slave capture, request pipeline, access unit, row memory and return master
`timescale 1ns/1ps

module mem_bus_controller
#(
   parameter int MEM_LINES = 64
)
(
   input  logic                            bus_clk,
   input  logic                            rst_n,
   input  logic                            dest_in,
   input  logic [15:0]                     bus_a,
   input  logic                            bus_rw,
   input  mem_ctrl_pkg::wsize_t            bus_size,
   input  mem_ctrl_pkg::src_t              bus_src,
   input  logic [mem_ctrl_pkg::BEAT_W-1:0] bus_d,
   input  logic                            bg,
   input  logic                            ack_in,
   output logic                            ack_out,
   output logic                            br,
   output logic                            dest_out_ic,
   output logic                            dest_out_dc,
   output logic [15:0]                     out_a,
   output logic [mem_ctrl_pkg::BEAT_W-1:0] out_d,
   output logic                            out_d_valid
);

   logic                              wr_latch_empty;
   logic                              blk_load;
   logic [mem_ctrl_pkg::BLOCK_W-1:0]  blk_data;
   logic                              rd_valid;
   mem_ctrl_pkg::mem_addr_u           rd_addr;
   mem_ctrl_pkg::src_t                rd_src;
   mem_ctrl_pkg::wsize_t              rd_size;
   logic                              rd_rw;
   logic [mem_ctrl_pkg::BLOCK_W-1:0]  rd_data;
   logic                              access_done;
   logic                              ret_ready;
   logic                              ret_done;
   logic [mem_ctrl_pkg::BLOCK_W-1:0]  ret_data;
   logic [$clog2(MEM_LINES)-1:0]      mem_addr;
   logic                              mem_en;
   logic                              mem_wr;
   logic [mem_ctrl_pkg::LINE_W-1:0]   mem_wdata;
   logic [mem_ctrl_pkg::LINE_W/8-1:0] mem_be;
   logic [mem_ctrl_pkg::LINE_W-1:0]   mem_rdata;

   bus_slave_capture u_slave
   (
      .bus_clk(bus_clk), .rst_n(rst_n), .dest_in(dest_in), .bus_rw(bus_rw),
      .bus_d(bus_d), .wr_latch_empty(wr_latch_empty), .ack_out(ack_out),
      .blk_data(blk_data), .blk_load(blk_load)
   );

   request_latches u_latches
   (
      .bus_clk(bus_clk), .rst_n(rst_n), .dest_in(dest_in), .blk_load(blk_load),
      .blk_data(blk_data), .bus_a(bus_a), .bus_rw(bus_rw), .bus_size(bus_size),
      .bus_src(bus_src), .access_done(access_done), .wr_latch_empty(wr_latch_empty),
      .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_src(rd_src), .rd_size(rd_size),
      .rd_rw(rd_rw), .rd_data(rd_data)
   );

   mem_access_unit #(.MEM_LINES(MEM_LINES)) u_access
   (
      .bus_clk(bus_clk), .rst_n(rst_n), .rd_valid(rd_valid), .rd_addr(rd_addr),
      .rd_size(rd_size), .rd_rw(rd_rw), .rd_data(rd_data), .ret_done(ret_done),
      .mem_addr(mem_addr), .mem_en(mem_en), .mem_wr(mem_wr), .mem_wdata(mem_wdata),
      .mem_be(mem_be), .mem_rdata(mem_rdata), .access_done(access_done),
      .ret_ready(ret_ready), .ret_data(ret_data)
   );

   mem_array #(.MEM_LINES(MEM_LINES)) u_mem
   (
      .bus_clk(bus_clk), .mem_addr(mem_addr), .mem_en(mem_en), .mem_wr(mem_wr),
      .mem_wdata(mem_wdata), .mem_be(mem_be), .mem_rdata(mem_rdata)
   );

   bus_return_master u_master
   (
      .bus_clk(bus_clk), .rst_n(rst_n), .ret_ready(ret_ready), .rd_addr(rd_addr),
      .rd_src(rd_src), .ret_data(ret_data), .bg(bg), .ack_in(ack_in), .br(br),
      .dest_out_ic(dest_out_ic), .dest_out_dc(dest_out_dc), .out_a(out_a),
      .out_d(out_d), .out_d_valid(out_d_valid), .ret_done(ret_done)
   );

endmodule

// ==== tb_clock_gen.sv ====
// Free-running testbench clock
`timescale 1ns/1ps

module tb_clock_gen
#(
   parameter int PERIOD_NS = 4
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS/2) clk = ~clk;
   end

endmodule

// ==== tb_mem_bus_controller.sv ====
// Testbench for the memory bus controller
// Replays the tests file, plays arbiter and caches, checks every returned read
`timescale 1ns/1ps

module tb_mem_bus_controller;

   localparam int MAX_TESTS = 64;
   localparam int FIELDS    = 6;

   logic                            bus_clk;
   logic                            rst_n;
   logic                            dest_in;
   logic [15:0]                     bus_a;
   logic                            bus_rw;
   mem_ctrl_pkg::wsize_t            bus_size;
   mem_ctrl_pkg::src_t              bus_src;
   logic [mem_ctrl_pkg::BEAT_W-1:0] bus_d;
   logic                            bg;
   logic                            ack_in;
   logic                            ack_out;
   logic                            br;
   logic                            dest_out_ic;
   logic                            dest_out_dc;
   logic [15:0]                     out_a;
   logic [mem_ctrl_pkg::BEAT_W-1:0] out_d;
   logic                            out_d_valid;

   // Per line: op, address, size, source, data, expected read data
   logic [mem_ctrl_pkg::BLOCK_W-1:0] vectors [0:MAX_TESTS*FIELDS-1];
   int num_tests;
   int num_reads;
   int returned;
   int errors;

   // Reads accepted but not yet returned, oldest first
   logic [15:0]                      exp_addr_q [$];
   mem_ctrl_pkg::src_t               exp_src_q  [$];
   logic [mem_ctrl_pkg::BLOCK_W-1:0] exp_data_q [$];

   tb_clock_gen #(.PERIOD_NS(4)) clk_gen (.clk(bus_clk));

   mem_bus_controller #(.MEM_LINES(64)) UUT
   (
      .bus_clk(bus_clk), .rst_n(rst_n), .dest_in(dest_in), .bus_a(bus_a),
      .bus_rw(bus_rw), .bus_size(bus_size), .bus_src(bus_src), .bus_d(bus_d),
      .bg(bg), .ack_in(ack_in), .ack_out(ack_out), .br(br),
      .dest_out_ic(dest_out_ic), .dest_out_dc(dest_out_dc), .out_a(out_a),
      .out_d(out_d), .out_d_valid(out_d_valid)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   task automatic report_fail(input string msg);
      errors++;
      $display("FAIL @ %0t ns: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic compare_level(input logic got, input logic exp, input string what);
      if (got !== exp)
         report_fail($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   task automatic compare_src(input mem_ctrl_pkg::src_t got, input mem_ctrl_pkg::src_t exp,
                              input string what);
      if (got !== exp)
         report_fail($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   task automatic compare_addr(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
      if (got !== exp)
         report_fail($sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   task automatic compare_data(input logic [mem_ctrl_pkg::BLOCK_W-1:0] got,
                               input logic [mem_ctrl_pkg::BLOCK_W-1:0] exp,
                               input string what);
      if (got !== exp)
         report_fail($sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Requester side
   task automatic send_request(input int idx);
      logic [mem_ctrl_pkg::BLOCK_W-1:0] data;
      data     = vectors[idx*FIELDS+4];
      bus_a    = vectors[idx*FIELDS+1][15:0];
      bus_rw   = vectors[idx*FIELDS][0];
      bus_size = vectors[idx*FIELDS+2][2:0];
      bus_src  = vectors[idx*FIELDS+3][2:0];
      dest_in  = 1'b1;
      // Keep the strobe up until the controller acknowledges
      do
      begin
         @(posedge bus_clk);
         #1;
      end while (!ack_out);
      dest_in = 1'b0;
      if (!bus_rw)
      begin
         exp_addr_q.push_back(bus_a);
         exp_src_q.push_back(bus_src);
         exp_data_q.push_back(vectors[idx*FIELDS+5]);
         if (exp_addr_q.size() > 2)
            report_fail("more reads acknowledged than the two latches can hold");
         @(posedge bus_clk);
         #1;
         compare_level(ack_out, 1'b0, "ack_out after its pulse");
      end
      else
      begin
         for (int b = 0; b < 4; b++)
         begin
            @(posedge bus_clk);
            #1;
            bus_d = data[b*mem_ctrl_pkg::BEAT_W +: mem_ctrl_pkg::BEAT_W];
         end
         @(posedge bus_clk);
         #1;
         compare_level(ack_out, 1'b0, "ack_out after its pulse");
      end
   endtask

   initial
   begin
      rst_n     = 1'b0;
      dest_in   = 1'b0;
      bus_a     = '0;
      bus_rw    = 1'b0;
      bus_size  = '0;
      bus_src   = '0;
      bus_d     = '0;
      bg        = 1'b0;
      ack_in    = 1'b0;
      errors    = 0;
      returned  = 0;
      num_tests = 0;
      num_reads = 0;
      void'($urandom(29219));
      $readmemh("mem_bus_controller_tests.txt", vectors);
      // An op of f ends the list
      while (num_tests < MAX_TESTS && vectors[num_tests*FIELDS][3:0] != 4'hf)
      begin
         if (vectors[num_tests*FIELDS][0] == 1'b0)
            num_reads++;
         num_tests++;
      end
      if (num_tests == MAX_TESTS)
      begin
         $display("The tests file has no end marker line");
         $display("RESULT: FAIL");
         $fatal(1, "bad tests file");
      end

      repeat (8) @(posedge bus_clk);
      #1;
      rst_n = 1'b1;

      // Quiet bus before the first request
      repeat (3)
      begin
         @(posedge bus_clk);
         #1;
         compare_level(ack_out, 1'b0, "ack_out after reset");
         compare_level(br, 1'b0, "br after reset");
         compare_level(dest_out_ic, 1'b0, "dest_out_ic after reset");
         compare_level(dest_out_dc, 1'b0, "dest_out_dc after reset");
         compare_level(out_d_valid, 1'b0, "out_d_valid after reset");
      end

      for (int i = 0; i < num_tests; i++)
         send_request(i);

      while (returned < num_reads)
         @(posedge bus_clk);
      repeat (4) @(posedge bus_clk);

      if (errors == 0)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
      begin
         $display("RESULT: FAIL");
         $fatal(1, "errors found");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Arbiter and cache side
   initial
   begin
      int                               delay;
      logic [mem_ctrl_pkg::BLOCK_W-1:0] got;
      logic [15:0]                      eaddr;
      mem_ctrl_pkg::src_t               esrc;
      logic [mem_ctrl_pkg::BLOCK_W-1:0] edata;
      forever
      begin
         @(posedge bus_clk);
         #1;
         // No strobes or beats outside a granted return
         if (rst_n && !br)
         begin
            compare_level(out_d_valid, 1'b0, "out_d_valid outside a return");
            compare_level(dest_out_ic, 1'b0, "dest_out_ic outside a return");
            compare_level(dest_out_dc, 1'b0, "dest_out_dc outside a return");
         end
         if (rst_n && br)
         begin
            delay = $urandom % 7;
            repeat (delay)
            begin
               compare_level(br, 1'b1, "br while grant is withheld");
               @(posedge bus_clk);
               #1;
            end
            bg = 1'b1;
            @(posedge bus_clk);
            #1;
            bg = 1'b0;
            if (exp_addr_q.size() == 0)
               report_fail("read data returned with no read outstanding");
            eaddr = exp_addr_q[0];
            esrc  = exp_src_q[0];
            edata = exp_data_q[0];
            // DMA has no strobe of its own
            compare_src({1'b0, dest_out_dc, dest_out_ic}, esrc & 3'b011, "dest strobes");
            compare_addr(out_a, eaddr, "out_a");
            if (esrc != mem_ctrl_pkg::SRC_DMA)
            begin
               delay = $urandom % 7;
               repeat (delay)
               begin
                  @(posedge bus_clk);
                  #1;
               end
               ack_in = 1'b1;
            end
            @(posedge bus_clk);
            #1;
            ack_in = 1'b0;
            for (int b = 0; b < 4; b++)
            begin
               compare_level(out_d_valid, 1'b1, "out_d_valid during return");
               got[b*mem_ctrl_pkg::BEAT_W +: mem_ctrl_pkg::BEAT_W] = out_d;
               if (b < 3)
               begin
                  @(posedge bus_clk);
                  #1;
               end
            end
            compare_data(got, edata, $sformatf("read data from %h", eaddr));
            // The read latch frees with the last beat
            void'(exp_addr_q.pop_front());
            void'(exp_src_q.pop_front());
            void'(exp_data_q.pop_front());
            returned++;
         end
      end
   end

   // Watchdog
   initial
   begin
      wait (rst_n === 1'b1);
      repeat (num_tests*200) @(posedge bus_clk);
      $display("Timeout: the tests did not finish in time");
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

// ==== mem_bus_controller_tests.txt ====
// op(1 write, 0 read, f end) addr size src data expected
// Full writes, partial writes by shift and mask, half select, row wrap, DMA
1 0040 4 1 00112233445566778899aabbccddeeff 0
0 0040 0 1 0 00112233445566778899aabbccddeeff
1 0050 4 2 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0
0 0050 0 2 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0
1 0044 2 1 111111112222222233333333deadbeef 0
1 004e 2 2 999999998888888877777777c3d4a1b2 0
1 0049 0 1 0000000000000000000000000000005a 0
0 0040 0 2 0 a1b2223344555a77deadbeefccddeeff
1 0052 1 1 0000000000000000000000000000c0de 0
1 0058 3 2 00000000000000000123456789abcdef 0
0 0050 0 1 0 0123456789abcdef8796a5b4c0dee1f0
0 0840 0 2 0 a1b2223344555a77deadbeefccddeeff
0 0847 0 1 0 a1b2223344555a77deadbeefccddeeff
0 0040 0 4 0 a1b2223344555a77deadbeefccddeeff
0 0050 0 1 0 0123456789abcdef8796a5b4c0dee1f0
1 00a0 4 1 fedcba98765432100a0b0c0d0e0f1011 0
1 00b0 4 2 13579bdf2468ace055aa55aaa5a5a5a5 0
0 00a0 0 1 0 fedcba98765432100a0b0c0d0e0f1011
0 00b0 0 2 0 13579bdf2468ace055aa55aaa5a5a5a5
0 00a0 0 4 0 fedcba98765432100a0b0c0d0e0f1011
0 00b4 0 1 0 13579bdf2468ace055aa55aaa5a5a5a5
f 0 0 0 0 0

// ==== mem_bus_controller.f ====
mem_ctrl_pkg.sv
bus_slave_capture.sv
request_latches.sv
mem_access_unit.sv
mem_array.sv
bus_return_master.sv
mem_bus_controller.sv
tb_clock_gen.sv
tb_mem_bus_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_mem_bus_controller \
   -f mem_bus_controller.f
out=$(./obj_dir/Vtb_mem_bus_controller) || true
echo "$out"
if echo "$out" | grep -q "RESULT: PASS"; then
   exit 0
fi
exit 1
